//--- include/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// client ports sharing the test memory
`define MEM_N_PORTS 4

// word offset inside one client region
`define MEM_LOCAL_AW 8

`define MEM_DATA_W 32

// entries in each request queue and each response queue
`define MEM_FIFO_DEPTH 4

// configuration window, in cycles after rst_i drops
`define MEM_CFG_CYCLES 12

// flops between end of configuration and core reset release
`define MEM_RESET_DEPTH 3

`endif

//--- hdl/dma_pkg.sv
`include "mem_params.svh"

package dma_pkg;

  // one data word as a client sees it
  typedef logic [`MEM_DATA_W-1:0] dma_data_t;

  // word offset within the client's own region
  typedef logic [`MEM_LOCAL_AW-1:0] dma_offset_t;

  // single word request from a client
  typedef struct packed {
    logic        wr;
    dma_offset_t offset;
    // don't care on reads
    dma_data_t   data;
  } dma_req_s;

endpackage

//--- hdl/mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

  typedef logic [$clog2(`MEM_N_PORTS)-1:0] port_idx_t;

  // port number on top, so every client owns a private slice of memory
  typedef logic [$clog2(`MEM_N_PORTS)+`MEM_LOCAL_AW-1:0] mem_addr_t;

  // command as seen by the memory, tagged with the issuing port
  typedef struct packed {
    logic                   wr;
    mem_addr_t              addr;
    logic [`MEM_DATA_W-1:0] data;
    port_idx_t              port;
  } mem_cmd_s;

endpackage

//--- hdl/dma_fifo.sv
`include "mem_params.svh"

module dma_fifo #(
  parameter type payload_t = logic,
  parameter int  depth_p   = `MEM_FIFO_DEPTH,
  localparam int ptr_w_lp  = (depth_p > 1) ? $clog2(depth_p) : 1,
  localparam int cnt_w_lp  = $clog2(depth_p + 1)
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  payload_t            data_i,
  input  logic                pop_i,
  output logic                valid_o,
  output payload_t            data_o,
  output logic                full_o,
  output logic [cnt_w_lp-1:0] free_slots_o
);

  payload_t            mem_r [depth_p];
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [cnt_w_lp-1:0] count_r;

  // wrap explicitly so depth need not be a power of two
  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
    return (ptr == ptr_w_lp'(depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (pop_i) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      count_r <= count_r + cnt_w_lp'(push_i) - cnt_w_lp'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  assign valid_o      = (count_r != '0);
  assign full_o       = (count_r == cnt_w_lp'(depth_p));
  assign free_slots_o = cnt_w_lp'(depth_p) - count_r;
  assign data_o       = mem_r[rd_ptr_r];

  // callers must honour full and valid
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o)
    else $error("push into a full queue");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> valid_o)
    else $error("pop from an empty queue");

endmodule

//--- hdl/reset_release.sv
`include "mem_params.svh"

module reset_release (
  input  logic clk_i,
  input  logic rst_i,
  output logic cfg_done_o,
  output logic core_rst_o
);

  localparam int cnt_w_lp = $clog2(`MEM_CFG_CYCLES + 1);

  logic [cnt_w_lp-1:0]         cfg_cnt_r;
  logic                        cfg_done_r;
  logic [`MEM_RESET_DEPTH-1:0] rst_chain_r;

  // count from the first edge that sees rst_i low
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_cnt_r  <= '0;
      cfg_done_r <= 1'b0;
    end else if (!cfg_done_r) begin
      cfg_cnt_r  <= cfg_cnt_r + 1'b1;
      cfg_done_r <= (cfg_cnt_r == cnt_w_lp'(`MEM_CFG_CYCLES - 1));
    end
  end

  // not-done walks down the chain, core leaves reset at the far end
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rst_chain_r <= '1;
    end else begin
      rst_chain_r <= {rst_chain_r[`MEM_RESET_DEPTH-2:0], ~cfg_done_r};
    end
  end

  assign cfg_done_o = cfg_done_r;
  assign core_rst_o = rst_chain_r[`MEM_RESET_DEPTH-1];

  // done rises one full window after rst_i drops
  a_done_timing: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(cfg_done_o) |-> !$past(rst_i, `MEM_CFG_CYCLES)
                          && $past(rst_i, `MEM_CFG_CYCLES + 1))
    else $error("cfg_done_o rose outside the end of the configuration window");

endmodule

//--- hdl/dma_arbiter.sv
`include "mem_params.svh"

module dma_arbiter
  import dma_pkg::*;
  import mem_pkg::*;
#(
  localparam int n_lp     = `MEM_N_PORTS,
  localparam int cnt_w_lp = $clog2(`MEM_FIFO_DEPTH + 1)
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [n_lp-1:0]               head_valid_i,
  input  dma_req_s [n_lp-1:0]           head_pkt_i,
  input  logic [n_lp-1:0][cnt_w_lp-1:0] free_slots_i,
  input  logic [n_lp-1:0]               rd_done_i,
  output logic [n_lp-1:0]               pop_o,
  output logic                          cmd_valid_o,
  output mem_cmd_s                      cmd_o
);

  logic [n_lp-1:0]               eligible;
  logic [n_lp-1:0][cnt_w_lp-1:0] rd_inflight_r;
  port_idx_t                     last_r;
  port_idx_t                     winner;
  logic                          found;

  // a read needs a response slot not yet claimed by an earlier read
  always_comb begin
    for (int i = 0; i < n_lp; i++) begin
      eligible[i] = head_valid_i[i]
                    && (head_pkt_i[i].wr || (free_slots_i[i] > rd_inflight_r[i]));
    end
  end

  // search starts one past the last winner, which comes last
  always_comb begin
    port_idx_t idx;
    found  = 1'b0;
    winner = last_r;
    for (int k = 1; k <= n_lp; k++) begin
      idx = port_idx_t'((int'(last_r) + k) % n_lp);
      if (!found && eligible[idx]) begin
        found  = 1'b1;
        winner = idx;
      end
    end
  end

  always_comb begin
    pop_o         = '0;
    pop_o[winner] = found;
  end

  // full address is the winner's region plus its local offset
  always_comb begin
    cmd_o.wr   = head_pkt_i[winner].wr;
    cmd_o.addr = {winner, head_pkt_i[winner].offset};
    cmd_o.data = head_pkt_i[winner].data;
    cmd_o.port = winner;
  end

  assign cmd_valid_o = found;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_r <= port_idx_t'(n_lp - 1);
    end else if (found) begin
      last_r <= winner;
    end
  end

  // reads granted but not yet pushed into their response queue
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_inflight_r <= '0;
    end else begin
      for (int i = 0; i < n_lp; i++) begin
        rd_inflight_r[i] <= rd_inflight_r[i] + cnt_w_lp'(pop_o[i] && !head_pkt_i[i].wr)
                            - cnt_w_lp'(rd_done_i[i]);
      end
    end
  end

  // every read in flight must have a free response slot waiting for it
  for (genvar i = 0; i < n_lp; i++) begin : g_credit
    a_credit: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_inflight_r[i] <= free_slots_i[i])
      else $error("port %0d has more reads in flight than response slots", i);
  end

endmodule

//--- hdl/test_mem.sv
`include "mem_params.svh"

module test_mem
  import dma_pkg::*;
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      cmd_valid_i,
  input  mem_cmd_s  cmd_i,
  output logic      rd_valid_o,
  output port_idx_t rd_port_o,
  output dma_data_t rd_data_o,
  input  logic      rst_i
);

  // 4 regions of 256 words
  localparam int words_lp = `MEM_N_PORTS * (2 ** `MEM_LOCAL_AW);

  dma_data_t mem_r [words_lp];
  logic      rd_valid_r;
  port_idx_t rd_port_r;
  dma_data_t rd_data_r;

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_i.wr) begin
      mem_r[cmd_i.addr] <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_valid_r <= 1'b0;
    end else begin
      rd_valid_r <= cmd_valid_i && !cmd_i.wr;
    end
  end

  // read data and its port tag leave together one cycle later
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && !cmd_i.wr) begin
      rd_data_r <= mem_r[cmd_i.addr];
      rd_port_r <= cmd_i.port;
    end
  end

  assign rd_valid_o = rd_valid_r;
  assign rd_port_o  = rd_port_r;
  assign rd_data_o  = rd_data_r;

  // a port may only touch its own region
  a_region: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_valid_i |-> (cmd_i.addr[$bits(mem_addr_t)-1 -: $bits(port_idx_t)] == cmd_i.port))
    else $error("command address outside the issuing port's region");

endmodule

//--- hdl/mem_sys_top.sv
`include "mem_params.svh"

module mem_sys_top
  import dma_pkg::*;
  import mem_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  output logic                         cfg_done_o,
  input  logic [`MEM_N_PORTS-1:0]      req_valid_i,
  output logic [`MEM_N_PORTS-1:0]      req_ready_o,
  input  dma_req_s [`MEM_N_PORTS-1:0]  req_pkt_i,
  output logic [`MEM_N_PORTS-1:0]      rsp_valid_o,
  input  logic [`MEM_N_PORTS-1:0]      rsp_ready_i,
  output dma_data_t [`MEM_N_PORTS-1:0] rsp_data_o
);

  localparam int cnt_w_lp = $clog2(`MEM_FIFO_DEPTH + 1);

  logic                                  core_rst;
  logic [`MEM_N_PORTS-1:0]               req_full;
  logic [`MEM_N_PORTS-1:0]               head_valid;
  dma_req_s [`MEM_N_PORTS-1:0]           head_pkt;
  logic [`MEM_N_PORTS-1:0]               pop;
  logic [`MEM_N_PORTS-1:0][cnt_w_lp-1:0] free_slots;
  logic [`MEM_N_PORTS-1:0]               rd_done;
  logic                                  cmd_valid;
  mem_cmd_s                              cmd;
  logic                                  rd_valid;
  port_idx_t                             rd_port;
  dma_data_t                             rd_data;

  reset_release rst_rel (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .cfg_done_o(cfg_done_o),
    .core_rst_o(core_rst)
  );

  for (genvar i = 0; i < `MEM_N_PORTS; i++) begin : g_port
    // no requests taken while the core is still held in reset
    assign req_ready_o[i] = ~req_full[i] & ~core_rst;
    assign rd_done[i]     = rd_valid && (rd_port == port_idx_t'(i));

    dma_fifo #(.payload_t(dma_req_s), .depth_p(`MEM_FIFO_DEPTH)) req_q (
      .clk_i       (clk_i),
      .rst_i       (core_rst),
      .push_i      (req_valid_i[i] & req_ready_o[i]),
      .data_i      (req_pkt_i[i]),
      .pop_i       (pop[i]),
      .valid_o     (head_valid[i]),
      .data_o      (head_pkt[i]),
      .full_o      (req_full[i]),
      .free_slots_o()
    );

    dma_fifo #(.payload_t(dma_data_t), .depth_p(`MEM_FIFO_DEPTH)) rsp_q (
      .clk_i       (clk_i),
      .rst_i       (core_rst),
      .push_i      (rd_done[i]),
      .data_i      (rd_data),
      .pop_i       (rsp_valid_o[i] & rsp_ready_i[i]),
      .valid_o     (rsp_valid_o[i]),
      .data_o      (rsp_data_o[i]),
      .full_o      (),
      .free_slots_o(free_slots[i])
    );
  end

  dma_arbiter arb (
    .clk_i       (clk_i),
    .rst_i       (core_rst),
    .head_valid_i(head_valid),
    .head_pkt_i  (head_pkt),
    .free_slots_i(free_slots),
    .rd_done_i   (rd_done),
    .pop_o       (pop),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd)
  );

  test_mem mem (
    .clk_i      (clk_i),
    .cmd_valid_i(cmd_valid),
    .cmd_i      (cmd),
    .rd_valid_o (rd_valid),
    .rd_port_o  (rd_port),
    .rd_data_o  (rd_data),
    .rst_i      (core_rst)
  );

endmodule

//--- bench/tb_top.sv
`include "mem_params.svh"

module tb_top
  import dma_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_lp          = `MEM_N_PORTS;
  localparam int words_lp      = 2 ** `MEM_LOCAL_AW;
  localparam int ready_edge_lp = `MEM_CFG_CYCLES + `MEM_RESET_DEPTH;
  localparam int stall_port_lp = 2;
  // reset, single port, random, stall and fairness test lengths
  localparam int timeout_lp    = 4 * ((16 + 24) + 64 + 2000 + 200 + 400);
  localparam int idle_lp       = 0;
  localparam int script_lp     = 1;
  localparam int random_lp     = 2;
  localparam int reads_lp      = 3;
  localparam int writes_lp     = 4;

  logic                 clk_i;
  logic                 rst_i;
  logic                 cfg_done_o;
  logic [n_lp-1:0]      req_valid_i;
  logic [n_lp-1:0]      req_ready_o;
  dma_req_s [n_lp-1:0]  req_pkt_i;
  logic [n_lp-1:0]      rsp_valid_o;
  logic [n_lp-1:0]      rsp_ready_i;
  dma_data_t [n_lp-1:0] rsp_data_o;

  // client state and reference model
  logic [n_lp-1:0]      pend_valid;
  dma_req_s [n_lp-1:0]  pend_pkt;
  logic [n_lp-1:0]      rsp_rdy;
  dma_req_s             script_q [$];
  dma_data_t            model_mem [n_lp][words_lp];
  bit                   written [n_lp][words_lp];
  dma_data_t            exp_q [n_lp][$];
  int                   acc_cnt [n_lp];
  int                   rd_acc_cnt [n_lp];
  int                   rsp_cnt [n_lp];
  int                   mode;
  int                   seed;
  int                   err_cnt;
  int                   tests_run;
  int                   tests_bad;
  int                   collide_cnt;
  int                   cycle_cnt = 0;

  mem_sys_top dut (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_done_o (cfg_done_o),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_pkt_i  (req_pkt_i),
    .rsp_valid_o(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_data_o (rsp_data_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_lp) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic accept_request(int p);
    dma_req_s pkt;
    pkt = req_pkt_i[p];
    acc_cnt[p]++;
    if (pkt.wr) begin
      model_mem[p][pkt.offset] = pkt.data;
      written[p][pkt.offset]   = 1'b1;
    end else begin
      // ports complete in order, so the value is known at transfer
      rd_acc_cnt[p]++;
      exp_q[p].push_back(model_mem[p][pkt.offset]);
      for (int q = 0; q < n_lp; q++) begin
        if (q != p && written[q][pkt.offset]
            && model_mem[q][pkt.offset] != model_mem[p][pkt.offset]) begin
          collide_cnt++;
        end
      end
    end
  endtask

  task automatic check_response(int p);
    dma_data_t exp_data;
    rsp_cnt[p]++;
    assert (exp_q[p].size() != 0) else begin
      $display("port %0d returned a response that no read asked for", p);
      err_cnt++;
    end
    if (exp_q[p].size() != 0) begin
      exp_data = exp_q[p].pop_front();
      assert (rsp_data_o[p] == exp_data) else begin
        $display("Fail rsp_data_o[%0d]: expected %h, got %h", p, exp_data, rsp_data_o[p]);
        err_cnt++;
      end
    end
  endtask

  task automatic new_request(int p, bit want_wr);
    logic [31:0] rnd;
    dma_req_s    pkt;
    // 16 offsets so that ports collide often
    rnd        = $random(seed);
    pkt.offset = dma_offset_t'(rnd[3:0]);
    pkt.wr     = want_wr || !written[p][pkt.offset];
    pkt.data   = $random(seed);
    pend_pkt[p]   = pkt;
    pend_valid[p] = 1'b1;
  endtask

  task automatic make_requests();
    logic [31:0] rnd;
    for (int p = 0; p < n_lp; p++) begin
      if (!pend_valid[p]) begin
        case (mode)
          script_lp: begin
            if (p == 0 && script_q.size() != 0) begin
              pend_pkt[p]   = script_q.pop_front();
              pend_valid[p] = 1'b1;
            end
          end
          random_lp: begin
            rnd = $random(seed);
            if (rnd[1:0] != 2'b00) begin
              new_request(p, rnd[2]);
            end
          end
          reads_lp:  new_request(p, 1'b0);
          writes_lp: new_request(p, 1'b1);
          default: ;
        endcase
      end
    end
  endtask

  // outputs are read before this edge's updates land
  task automatic run_cycle();
    @(posedge clk_i);
    for (int p = 0; p < n_lp; p++) begin
      if (req_valid_i[p] && req_ready_o[p]) begin
        pend_valid[p] = 1'b0;
        accept_request(p);
      end
      if (rsp_valid_o[p] && rsp_ready_i[p]) begin
        check_response(p);
      end
    end
    make_requests();
    req_valid_i <= pend_valid;
    req_pkt_i   <= pend_pkt;
    rsp_ready_i <= rsp_rdy;
  endtask

  function automatic bit busy();
    bit b;
    b = (pend_valid != '0) || (script_q.size() != 0);
    for (int p = 0; p < n_lp; p++) begin
      if (exp_q[p].size() != 0) begin
        b = 1'b1;
      end
    end
    return b;
  endfunction

  task automatic finish_test(string name, int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: FAILED, %0d errors", tests_run, name, err_cnt - errs_before);
    end
  endtask

  initial begin
    int              errs;
    int              lo;
    int              hi;
    logic            exp_done;
    logic [n_lp-1:0] exp_rdy;
    dma_req_s        pkt;
    dma_offset_t     offs [32];
    clk_i = 1'b0;
    rst_i = 1'b1;
    req_valid_i = '0;
    req_pkt_i = '0;
    rsp_ready_i = '1;
    pend_valid = '0;
    pend_pkt = '0;
    rsp_rdy = '1;
    mode = idle_lp;
    seed = 27591;
    err_cnt = 0;
    tests_run = 0;
    tests_bad = 0;
    collide_cnt = 0;
    for (int p = 0; p < n_lp; p++) begin
      acc_cnt[p] = 0;
      rd_acc_cnt[p] = 0;
      rsp_cnt[p] = 0;
    end

    errs = err_cnt;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    // sample n shows the state left by edge n-1 after reset fell
    for (int n = 1; n <= 24; n++) begin
      run_cycle();
      exp_done = (n - 1 >= `MEM_CFG_CYCLES);
      exp_rdy  = (n - 1 >= ready_edge_lp) ? '1 : '0;
      assert (cfg_done_o == exp_done) else begin
        $display("Fail cfg_done_o: expected %h, got %h", exp_done, cfg_done_o);
        err_cnt++;
      end
      assert (req_ready_o == exp_rdy) else begin
        $display("Fail req_ready_o: expected %h, got %h", exp_rdy, req_ready_o);
        err_cnt++;
      end
    end
    finish_test("reset release", errs);

    errs = err_cnt;
    for (int i = 0; i < 32; i++) begin
      pkt.wr     = 1'b1;
      pkt.offset = dma_offset_t'($random(seed));
      pkt.data   = $random(seed);
      offs[i]    = pkt.offset;
      script_q.push_back(pkt);
    end
    for (int i = 0; i < 32; i++) begin
      pkt.wr     = 1'b0;
      pkt.offset = offs[i];
      pkt.data   = '0;
      script_q.push_back(pkt);
    end
    mode = script_lp;
    while (busy()) begin
      run_cycle();
    end
    mode = idle_lp;
    finish_test("port 0 write then read", errs);

    errs = err_cnt;
    collide_cnt = 0;
    mode = random_lp;
    repeat (2000) run_cycle();
    mode = idle_lp;
    while (busy()) begin
      run_cycle();
    end
    assert (collide_cnt != 0) else begin
      $display("no read hit an offset holding other data in another port's region");
      err_cnt++;
    end
    finish_test("all ports random", errs);

    errs = err_cnt;
    for (int p = 0; p < n_lp; p++) begin
      rsp_cnt[p] = 0;
      rd_acc_cnt[p] = 0;
    end
    rsp_rdy[stall_port_lp] = 1'b0;
    mode = reads_lp;
    repeat (100) run_cycle();
    // by now the stalled port has filled both of its queues
    for (int p = 0; p < n_lp; p++) begin
      rsp_cnt[p] = 0;
    end
    repeat (100) run_cycle();
    for (int p = 0; p < n_lp; p++) begin
      assert (p == stall_port_lp || rsp_cnt[p] != 0) else begin
        $display("port %0d completed no reads while port %0d was stalled", p, stall_port_lp);
        err_cnt++;
      end
    end
    // request queue plus response slots bound what a stalled port can take
    assert (rd_acc_cnt[stall_port_lp] <= 2 * `MEM_FIFO_DEPTH) else begin
      $display("Fail reads accepted on port %0d: expected <= %h, got %h", stall_port_lp,
               2 * `MEM_FIFO_DEPTH, rd_acc_cnt[stall_port_lp]);
      err_cnt++;
    end
    rsp_rdy = '1;
    mode = idle_lp;
    while (busy()) begin
      run_cycle();
    end
    finish_test("response back-pressure", errs);

    errs = err_cnt;
    for (int p = 0; p < n_lp; p++) begin
      acc_cnt[p] = 0;
    end
    mode = writes_lp;
    repeat (400) run_cycle();
    mode = idle_lp;
    lo = acc_cnt[0];
    hi = acc_cnt[0];
    for (int p = 1; p < n_lp; p++) begin
      lo = (acc_cnt[p] < lo) ? acc_cnt[p] : lo;
      hi = (acc_cnt[p] > hi) ? acc_cnt[p] : hi;
    end
    assert (hi - lo <= 1) else begin
      $display("Fail accepted request spread: expected <= %h, got %h", 1, hi - lo);
      err_cnt++;
    end
    while (busy()) begin
      run_cycle();
    end
    finish_test("fairness", errs);

    $display("%0d of %0d tests ok, %0d check errors", tests_run - tests_bad, tests_run,
             err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
hdl/dma_pkg.sv
hdl/mem_pkg.sv
hdl/dma_fifo.sv
hdl/reset_release.sv
hdl/dma_arbiter.sv
hdl/test_mem.sv
hdl/mem_sys_top.sv
bench/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failures found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
